/* logic/fetch_pkg.sv */
// ------------------------------
// Widths, vector types and PC sources shared by the fetch stage
// ------------------------------
package fetch_pkg;

        // ------------------------------
        // Machine word
        // ------------------------------
        localparam int XLEN = 32;

        typedef logic [XLEN-1:0] addr_t;
        typedef logic [XLEN-1:0] instr_t;

        // Parts of the exception vector
        typedef logic [23:0] trap_base_t;
        typedef logic [4:0]  exc_cause_t;

        // ------------------------------
        // Prefetch queue sizing
        // ------------------------------
        localparam int QUEUE_DEPTH = 4;
        localparam int QUEUE_PTR_W = 2;

        // Counts 0 to QUEUE_DEPTH, for queue fill and reads in flight
        typedef logic [2:0] credit_t;

        // ------------------------------
        // Redirect target select
        // ------------------------------
        typedef enum logic [1:0] {
                PC_BOOT = 2'd0,
                PC_JUMP = 2'd1,
                PC_EXC  = 2'd2,
                PC_ERET = 2'd3
        } pc_src_e;

endpackage

/* logic/axi_lite_pkg.sv */
// ------------------------------
// AXI4-Lite response codes and channel field types
// ------------------------------
package axi_lite_pkg;

        // Read response code
        typedef logic [1:0] axi_resp_t;

        localparam axi_resp_t RESP_OKAY   = 2'b00;
        localparam axi_resp_t RESP_EXOKAY = 2'b01;
        localparam axi_resp_t RESP_SLVERR = 2'b10;
        localparam axi_resp_t RESP_DECERR = 2'b11;

        // Protection field
        typedef logic [2:0] axi_prot_t;

        // Unprivileged, secure, instruction access
        localparam axi_prot_t PROT_INSTR = 3'b100;

endpackage

/* logic/fetch_req_unit.sv */
// ------------------------------
// Fetch request unit with next-PC selection and AXI4-Lite read tracking
// ------------------------------
`timescale 1ns/1ps

module fetch_req_unit (
        input  logic                    clk,
        input  logic                    arst_n_i,
        input  logic                    pc_set_i,
        input  fetch_pkg::pc_src_e      pc_mux_i,
        input  fetch_pkg::addr_t        boot_addr_i,
        input  fetch_pkg::addr_t        jump_target_i,
        input  fetch_pkg::addr_t        mepc_i,
        input  fetch_pkg::trap_base_t   trap_base_i,
        input  fetch_pkg::exc_cause_t   exc_cause_i,
        output fetch_pkg::addr_t        m_axi_araddr_o,
        output axi_lite_pkg::axi_prot_t m_axi_arprot_o,
        output logic                    m_axi_arvalid_o,
        input  logic                    m_axi_arready_i,
        input  fetch_pkg::instr_t       m_axi_rdata_i,
        input  axi_lite_pkg::axi_resp_t m_axi_rresp_i,
        input  logic                    m_axi_rvalid_i,
        output logic                    m_axi_rready_o,
        input  fetch_pkg::credit_t      queue_fill_i,
        output logic                    push_o,
        output fetch_pkg::instr_t       push_instr_o,
        output fetch_pkg::addr_t        push_pc_o,
        output logic                    push_err_o
);
        import fetch_pkg::*;
        import axi_lite_pkg::*;

        addr_t                  fetch_addr_q;
        addr_t                  stale_addr_q;
        addr_t                  cur_addr;
        addr_t                  target_addr;
        addr_t                  pc_fifo [QUEUE_DEPTH];
        logic                   boot_pend_q;
        logic                   stale_q;
        credit_t                inflight_q;
        credit_t                inflight_d;
        credit_t                discard_q;
        logic [QUEUE_PTR_W-1:0] pc_wr_ptr_q;
        logic [QUEUE_PTR_W-1:0] pc_rd_ptr_q;
        logic [3:0]             credit_sum;
        logic                   ar_fire;
        logic                   ar_wait;
        logic                   rsp_fire;

        // ------------------------------
        // Next-PC selection
        // ------------------------------
        always_comb begin
                case (pc_mux_i)
                        PC_JUMP: target_addr = jump_target_i;
                        PC_EXC:  target_addr = {trap_base_i, 1'b0, exc_cause_i, 2'b00};
                        PC_ERET: target_addr = mepc_i;
                        default: target_addr = boot_addr_i;
                endcase
        end

        // Boot address is used until the first handshake or redirect
        assign cur_addr   = boot_pend_q ? boot_addr_i : fetch_addr_q;
        assign credit_sum = {1'b0, inflight_q} + {1'b0, queue_fill_i};

        // A beat left waiting by a redirect keeps its old address
        // No request goes out while reset is held
        assign m_axi_arvalid_o = arst_n_i & (stale_q | (credit_sum < 4'(QUEUE_DEPTH)));
        assign m_axi_araddr_o  = stale_q ? stale_addr_q : cur_addr;
        assign m_axi_arprot_o  = PROT_INSTR;
        assign m_axi_rready_o  = 1'b1;

        assign ar_fire    = m_axi_arvalid_o & m_axi_arready_i;
        assign ar_wait    = m_axi_arvalid_o & ~m_axi_arready_i;
        assign rsp_fire   = m_axi_rvalid_i;
        assign inflight_d = inflight_q + credit_t'(ar_fire) - credit_t'(rsp_fire);

        // ------------------------------
        // Response path toward the queue
        // ------------------------------
        assign push_o       = rsp_fire & (discard_q == '0);
        assign push_instr_o = m_axi_rdata_i;
        assign push_pc_o    = pc_fifo[pc_rd_ptr_q];
        assign push_err_o   = (m_axi_rresp_i != RESP_OKAY);

        always_ff @(posedge clk or negedge arst_n_i) begin
                if (!arst_n_i) begin
                        boot_pend_q <= 1'b1;
                        stale_q     <= 1'b0;
                        inflight_q  <= '0;
                        discard_q   <= '0;
                        pc_wr_ptr_q <= '0;
                        pc_rd_ptr_q <= '0;
                end else begin
                        inflight_q <= inflight_d;
                        if (ar_fire)
                                pc_wr_ptr_q <= pc_wr_ptr_q + 1'b1;
                        if (rsp_fire)
                                pc_rd_ptr_q <= pc_rd_ptr_q + 1'b1;
                        if (pc_set_i) begin
                                boot_pend_q <= 1'b0;
                                stale_q     <= ar_wait;
                                // Everything issued so far belongs to the old path
                                discard_q   <= inflight_d + credit_t'(ar_wait);
                        end else begin
                                if (ar_fire && !stale_q)
                                        boot_pend_q <= 1'b0;
                                if (ar_fire)
                                        stale_q <= 1'b0;
                                if (rsp_fire && discard_q != '0)
                                        discard_q <= discard_q - 1'b1;
                        end
                end
        end

        // Addresses of reads in flight, returned in request order
        always_ff @(posedge clk) begin
                if (pc_set_i)
                        fetch_addr_q <= target_addr;
                else if (ar_fire && !stale_q)
                        fetch_addr_q <= cur_addr + 32'd4;
                if (pc_set_i && ar_wait)
                        stale_addr_q <= m_axi_araddr_o;
                if (ar_fire)
                        pc_fifo[pc_wr_ptr_q] <= m_axi_araddr_o;
        end

        // ------------------------------
        // Assertions
        // ------------------------------
        a_ar_stable: assert property (@(posedge clk) disable iff (!arst_n_i)
                ar_wait |=> m_axi_arvalid_o && $stable(m_axi_araddr_o));

        a_credit_limit: assert property (@(posedge clk) disable iff (!arst_n_i)
                credit_sum <= 4'(QUEUE_DEPTH));

endmodule

/* logic/prefetch_queue.sv */
// ------------------------------
// Prefetch queue holding fetched words in a small ring buffer
// ------------------------------
`timescale 1ns/1ps

module prefetch_queue (
        input  logic               clk,
        input  logic               arst_n_i,
        input  logic               flush_i,
        input  logic               push_i,
        input  fetch_pkg::instr_t  push_instr_i,
        input  fetch_pkg::addr_t   push_pc_i,
        input  logic               push_err_i,
        input  logic               pop_i,
        output logic               head_valid_o,
        output fetch_pkg::instr_t  head_instr_o,
        output fetch_pkg::addr_t   head_pc_o,
        output logic               head_err_o,
        output fetch_pkg::credit_t fill_o
);
        import fetch_pkg::*;

        instr_t                 instr_mem [QUEUE_DEPTH];
        addr_t                  pc_mem    [QUEUE_DEPTH];
        logic                   err_mem   [QUEUE_DEPTH];
        logic [QUEUE_PTR_W-1:0] wr_ptr_q;
        logic [QUEUE_PTR_W-1:0] rd_ptr_q;
        credit_t                count_q;

        // Storage
        always_ff @(posedge clk) begin
                if (push_i) begin
                        instr_mem[wr_ptr_q] <= push_instr_i;
                        pc_mem[wr_ptr_q]    <= push_pc_i;
                        err_mem[wr_ptr_q]   <= push_err_i;
                end
        end

        // Pointers and fill, flush wins over push and pop
        always_ff @(posedge clk or negedge arst_n_i) begin
                if (!arst_n_i) begin
                        wr_ptr_q <= '0;
                        rd_ptr_q <= '0;
                        count_q  <= '0;
                end else if (flush_i) begin
                        wr_ptr_q <= '0;
                        rd_ptr_q <= '0;
                        count_q  <= '0;
                end else begin
                        if (push_i)
                                wr_ptr_q <= wr_ptr_q + 1'b1;
                        if (pop_i)
                                rd_ptr_q <= rd_ptr_q + 1'b1;
                        count_q <= count_q + credit_t'(push_i) - credit_t'(pop_i);
                end
        end

        assign head_valid_o = (count_q != '0);
        assign head_instr_o = instr_mem[rd_ptr_q];
        assign head_pc_o    = pc_mem[rd_ptr_q];
        assign head_err_o   = err_mem[rd_ptr_q];
        assign fill_o       = count_q;

        // ------------------------------
        // Assertions
        // ------------------------------
        a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n_i)
                push_i && !pop_i |-> count_q < credit_t'(QUEUE_DEPTH));

        a_no_underflow: assert property (@(posedge clk) disable iff (!arst_n_i)
                pop_i |-> count_q != '0);

endmodule

/* logic/decode_handoff.sv */
// ------------------------------
// Output register toward decode with a valid/ready handshake
// ------------------------------
`timescale 1ns/1ps

module decode_handoff (
        input  logic              clk,
        input  logic              arst_n_i,
        input  logic              flush_i,
        input  logic              head_valid_i,
        input  fetch_pkg::instr_t head_instr_i,
        input  fetch_pkg::addr_t  head_pc_i,
        input  logic              head_err_i,
        input  logic              id_ready_i,
        output logic              pop_o,
        output logic              instr_valid_o,
        output fetch_pkg::instr_t instr_o,
        output fetch_pkg::addr_t  pc_o,
        output logic              fetch_err_o
);
        import fetch_pkg::*;

        logic   valid_q;
        instr_t instr_q;
        addr_t  pc_q;
        logic   err_q;
        logic   load;

        // Refill when empty or when decode takes the current word
        assign load  = head_valid_i & (~valid_q | id_ready_i);
        assign pop_o = load;

        always_ff @(posedge clk or negedge arst_n_i) begin
                if (!arst_n_i)
                        valid_q <= 1'b0;
                else if (flush_i)
                        valid_q <= 1'b0;
                else if (load)
                        valid_q <= 1'b1;
                else if (id_ready_i)
                        valid_q <= 1'b0;
        end

        always_ff @(posedge clk) begin
                if (load) begin
                        instr_q <= head_instr_i;
                        pc_q    <= head_pc_i;
                        err_q   <= head_err_i;
                end
        end

        assign instr_valid_o = valid_q;
        assign instr_o       = instr_q;
        assign pc_o          = pc_q;
        assign fetch_err_o   = err_q;

        // Held word must not change until decode accepts it
        a_hold_stable: assert property (@(posedge clk) disable iff (!arst_n_i)
                valid_q && !id_ready_i && !flush_i |=>
                valid_q && $stable(instr_q) && $stable(pc_q) && $stable(err_q));

endmodule

/* logic/if_stage.sv */
// ------------------------------
// Instruction fetch stage top with request unit, queue and decode register
// ------------------------------
`timescale 1ns/1ps

module if_stage (
        input  logic                    clk,
        input  logic                    arst_n_i,
        input  logic                    pc_set_i,
        input  fetch_pkg::pc_src_e      pc_mux_i,
        input  fetch_pkg::addr_t        boot_addr_i,
        input  fetch_pkg::addr_t        jump_target_i,
        input  fetch_pkg::addr_t        mepc_i,
        input  fetch_pkg::trap_base_t   trap_base_i,
        input  fetch_pkg::exc_cause_t   exc_cause_i,
        output fetch_pkg::addr_t        m_axi_araddr_o,
        output axi_lite_pkg::axi_prot_t m_axi_arprot_o,
        output logic                    m_axi_arvalid_o,
        input  logic                    m_axi_arready_i,
        input  fetch_pkg::instr_t       m_axi_rdata_i,
        input  axi_lite_pkg::axi_resp_t m_axi_rresp_i,
        input  logic                    m_axi_rvalid_i,
        output logic                    m_axi_rready_o,
        output logic                    instr_valid_o,
        output fetch_pkg::instr_t       instr_o,
        output fetch_pkg::addr_t        pc_o,
        output logic                    fetch_err_o,
        input  logic                    id_ready_i
);
        import fetch_pkg::*;

        logic    push;
        instr_t  push_instr;
        addr_t   push_pc;
        logic    push_err;
        credit_t queue_fill;
        logic    head_valid;
        instr_t  head_instr;
        addr_t   head_pc;
        logic    head_err;
        logic    pop;

        // ------------------------------
        // Producer
        // ------------------------------
        fetch_req_unit u_fetch_req_unit (
                .clk             (clk),
                .arst_n_i        (arst_n_i),
                .pc_set_i        (pc_set_i),
                .pc_mux_i        (pc_mux_i),
                .boot_addr_i     (boot_addr_i),
                .jump_target_i   (jump_target_i),
                .mepc_i          (mepc_i),
                .trap_base_i     (trap_base_i),
                .exc_cause_i     (exc_cause_i),
                .m_axi_araddr_o  (m_axi_araddr_o),
                .m_axi_arprot_o  (m_axi_arprot_o),
                .m_axi_arvalid_o (m_axi_arvalid_o),
                .m_axi_arready_i (m_axi_arready_i),
                .m_axi_rdata_i   (m_axi_rdata_i),
                .m_axi_rresp_i   (m_axi_rresp_i),
                .m_axi_rvalid_i  (m_axi_rvalid_i),
                .m_axi_rready_o  (m_axi_rready_o),
                .queue_fill_i    (queue_fill),
                .push_o          (push),
                .push_instr_o    (push_instr),
                .push_pc_o       (push_pc),
                .push_err_o      (push_err)
        );

        // ------------------------------
        // Buffer
        // ------------------------------
        prefetch_queue u_prefetch_queue (
                .clk          (clk),
                .arst_n_i     (arst_n_i),
                .flush_i      (pc_set_i),
                .push_i       (push),
                .push_instr_i (push_instr),
                .push_pc_i    (push_pc),
                .push_err_i   (push_err),
                .pop_i        (pop),
                .head_valid_o (head_valid),
                .head_instr_o (head_instr),
                .head_pc_o    (head_pc),
                .head_err_o   (head_err),
                .fill_o       (queue_fill)
        );

        // ------------------------------
        // Consumer
        // ------------------------------
        decode_handoff u_decode_handoff (
                .clk           (clk),
                .arst_n_i      (arst_n_i),
                .flush_i       (pc_set_i),
                .head_valid_i  (head_valid),
                .head_instr_i  (head_instr),
                .head_pc_i     (head_pc),
                .head_err_i    (head_err),
                .id_ready_i    (id_ready_i),
                .pop_o         (pop),
                .instr_valid_o (instr_valid_o),
                .instr_o       (instr_o),
                .pc_o          (pc_o),
                .fetch_err_o   (fetch_err_o)
        );

endmodule

/* testbench/tb_clock_gen.sv */
// ------------------------------
// Testbench clock and reset source
// ------------------------------
`timescale 1ns/1ps

module tb_clock_gen (
        output logic clk,
        output logic arst_n_o
);

        // 10 ns period
        initial begin
                clk = 1'b0;
                forever #5 clk = ~clk;
        end

        // Reset held for 16 cycles, released away from the rising edge
        initial begin
                arst_n_o = 1'b0;
                repeat (16) @(posedge clk);
                @(negedge clk);
                arst_n_o = 1'b1;
        end

endmodule

/* testbench/if_checker.sv */
// ------------------------------
// Reference model of the decode stream and its comparisons
// ------------------------------
`timescale 1ns/1ps

module if_checker #(
        parameter logic [31:0] DATA_XOR = 32'h0
) (
        input  logic                    clk,
        input  logic                    arst_n_i,
        input  logic                    pc_set_i,
        input  fetch_pkg::pc_src_e      pc_mux_i,
        input  fetch_pkg::addr_t        boot_addr_i,
        input  fetch_pkg::addr_t        jump_target_i,
        input  fetch_pkg::addr_t        mepc_i,
        input  fetch_pkg::trap_base_t   trap_base_i,
        input  fetch_pkg::exc_cause_t   exc_cause_i,
        input  logic                    arvalid_i,
        input  axi_lite_pkg::axi_prot_t arprot_i,
        input  logic                    rready_i,
        input  logic                    instr_valid_i,
        input  fetch_pkg::instr_t       instr_i,
        input  fetch_pkg::addr_t        pc_i,
        input  logic                    fetch_err_i,
        input  logic                    id_ready_i,
        output int                      xfer_cnt_o,
        output int                      err_cnt_o
);
        import fetch_pkg::*;
        import axi_lite_pkg::*;

        addr_t  exp_pc;
        addr_t  target;
        addr_t  held_pc;
        instr_t held_instr;
        logic   waiting = 1'b0;
        int     xfers = 0;
        int     errors = 0;

        // Redirect target from the selected source
        always_comb begin
                case (pc_mux_i)
                        PC_JUMP: target = jump_target_i;
                        PC_EXC:  target = {trap_base_i, 1'b0, exc_cause_i, 2'b00};
                        PC_ERET: target = mepc_i;
                        default: target = boot_addr_i;
                endcase
        end

        task automatic compare(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
                if (actual !== expected) begin
                        $display("MISMATCH time=%0t signal=%s expected=%h actual=%h",
                                 $time, name, expected, actual);
                        errors++;
                end
        endtask

        // ------------------------------
        // Sampled on the rising edge, inputs settle on the falling edge
        // ------------------------------
        always @(posedge clk) begin
                if (!arst_n_i) begin
                        exp_pc  = boot_addr_i;
                        waiting = 1'b0;
                        if (instr_valid_i !== 1'b0) begin
                                $display("ERROR at %0t: instr_valid_o is high during reset", $time);
                                errors++;
                        end
                        if (arvalid_i !== 1'b0) begin
                                $display("ERROR at %0t: m_axi_arvalid_o is high during reset",
                                         $time);
                                errors++;
                        end
                end else begin
                        // A word waiting for decode must hold still
                        if (waiting) begin
                                compare("instr_valid_o", 32'd1, 32'(instr_valid_i));
                                compare("pc_o", held_pc, pc_i);
                                compare("instr_o", held_instr, instr_i);
                        end
                        if (instr_valid_i && id_ready_i) begin
                                compare("pc_o", exp_pc, pc_i);
                                compare("instr_o", exp_pc ^ DATA_XOR, instr_i);
                                compare("fetch_err_o", 32'(exp_pc[6:4] == 3'b111),
                                        32'(fetch_err_i));
                                xfers++;
                                exp_pc = exp_pc + 32'd4;
                        end
                        if (arvalid_i)
                                compare("m_axi_arprot_o", 32'(PROT_INSTR), 32'(arprot_i));
                        // Read responses are never refused
                        compare("m_axi_rready_o", 32'd1, 32'(rready_i));
                        if (pc_set_i)
                                exp_pc = target;
                        waiting    = instr_valid_i && !id_ready_i && !pc_set_i;
                        held_pc    = pc_i;
                        held_instr = instr_i;
                end
                xfer_cnt_o <= xfers;
                err_cnt_o  <= errors;
        end

endmodule

/* testbench/tb_if_stage.sv */
// ------------------------------
// Fetch stage testbench with AXI4-Lite memory model and random stimulus
// ------------------------------
`timescale 1ns/1ps

module tb_if_stage;
        import fetch_pkg::*;
        import axi_lite_pkg::*;

        localparam logic [31:0] DATA_XOR = 32'hA5C3_0F96;
        localparam addr_t BOOT_ADDR = 32'h0000_1000;
        localparam addr_t ERR_BASE  = 32'h0000_3040;
        localparam int RESET_CYCLES = 16;
        localparam int N_BOOT   = 32;
        localparam int N_REDIR  = 120;
        localparam int N_STALL  = 120;
        localparam int N_ERR    = 48;
        localparam int N_ROUNDS = 8;
        localparam int N_ROUND  = 12;
        localparam int TOTAL_XFERS = N_BOOT + N_REDIR + N_STALL + N_ERR + N_ROUNDS * N_ROUND;
        localparam int CYCLE_LIMIT = TOTAL_XFERS * 20 + RESET_CYCLES;

        logic       clk;
        logic       arst_n;
        logic       pc_set;
        pc_src_e    pc_mux;
        addr_t      boot_addr;
        addr_t      jump_target;
        addr_t      mepc;
        trap_base_t trap_base;
        exc_cause_t exc_cause;
        addr_t      araddr;
        axi_prot_t  arprot;
        logic       arvalid;
        logic       arready;
        instr_t     rdata;
        axi_resp_t  rresp;
        logic       rvalid;
        logic       rready;
        logic       instr_valid;
        instr_t     instr;
        addr_t      pc;
        logic       fetch_err;
        logic       id_ready;
        int         xfer_cnt;
        int         err_cnt;

        // Test control, written on the rising edge and read on the falling edge
        logic        mem_en = 1'b0;
        logic        stall = 1'b0;
        logic        kick = 1'b0;
        addr_t       kick_addr = '0;
        int          ready_thr = 16;
        int          redir_thr = 0;
        int          tests_passed = 0;
        int          tests_failed = 0;
        int          cycles = 0;
        addr_t       rsp_q [$];
        logic [15:0] lfsr_q = 16'd94;

        tb_clock_gen u_clock_gen (
                .clk      (clk),
                .arst_n_o (arst_n)
        );

        if_stage uut (
                .clk (clk), .arst_n_i (arst_n),
                .pc_set_i (pc_set), .pc_mux_i (pc_mux),
                .boot_addr_i (boot_addr), .jump_target_i (jump_target),
                .mepc_i (mepc), .trap_base_i (trap_base), .exc_cause_i (exc_cause),
                .m_axi_araddr_o (araddr), .m_axi_arprot_o (arprot),
                .m_axi_arvalid_o (arvalid), .m_axi_arready_i (arready),
                .m_axi_rdata_i (rdata), .m_axi_rresp_i (rresp),
                .m_axi_rvalid_i (rvalid), .m_axi_rready_o (rready),
                .instr_valid_o (instr_valid), .instr_o (instr), .pc_o (pc),
                .fetch_err_o (fetch_err), .id_ready_i (id_ready)
        );

        if_checker #(.DATA_XOR (DATA_XOR)) u_checker (
                .clk (clk), .arst_n_i (arst_n),
                .pc_set_i (pc_set), .pc_mux_i (pc_mux),
                .boot_addr_i (boot_addr), .jump_target_i (jump_target),
                .mepc_i (mepc), .trap_base_i (trap_base), .exc_cause_i (exc_cause),
                .arvalid_i (arvalid), .arprot_i (arprot), .rready_i (rready),
                .instr_valid_i (instr_valid), .instr_i (instr), .pc_i (pc),
                .fetch_err_i (fetch_err), .id_ready_i (id_ready),
                .xfer_cnt_o (xfer_cnt), .err_cnt_o (err_cnt)
        );

        // ------------------------------
        // Random bits
        // ------------------------------
        function automatic logic [15:0] lfsr_step(input logic [15:0] s);
                return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
        endfunction

        function automatic logic [31:0] rand_bits(input int n);
                logic [31:0] r;
                r = '0;
                for (int i = 0; i < n; i++) begin
                        lfsr_q = lfsr_step(lfsr_q);
                        r      = {r[30:0], lfsr_q[0]};
                end
                return r;
        endfunction

        // ------------------------------
        // Memory model, decode ready and redirects, all on the falling edge
        // ------------------------------
        always @(negedge clk) begin
                // Read data returns in request order, at least a cycle after its address
                if (mem_en && rsp_q.size() > 0 && rand_bits(2) != 0) begin
                        rvalid = 1'b1;
                        rdata  = rsp_q[0] ^ DATA_XOR;
                        rresp  = (rsp_q[0][6:4] == 3'b111) ? RESP_SLVERR : RESP_OKAY;
                        void'(rsp_q.pop_front());
                end else begin
                        rvalid = 1'b0;
                        rdata  = '0;
                        rresp  = RESP_OKAY;
                end
                arready = mem_en && (rand_bits(2) != 0);
                if (arready && arvalid)
                        rsp_q.push_back(araddr);
                id_ready = !stall && (rand_bits(4) < ready_thr);
                pc_set   = 1'b0;
                if (kick || (redir_thr != 0 && rand_bits(5) < redir_thr)) begin
                        pc_set      = 1'b1;
                        pc_mux      = kick ? PC_JUMP : pc_src_e'(rand_bits(2));
                        jump_target = kick ? kick_addr : rand_bits(30) << 2;
                        mepc        = rand_bits(30) << 2;
                        trap_base   = trap_base_t'(rand_bits(24));
                        exc_cause   = exc_cause_t'(rand_bits(5));
                        kick        = 1'b0;
                end
        end

        always @(posedge clk) begin
                cycles <= cycles + 1;
                if (cycles >= CYCLE_LIMIT) begin
                        $display("Timeout after %0d cycles with %0d transfers seen", cycles, xfer_cnt);
                        $display("Simulation failed");
                        $finish;
                end
        end

        task automatic run_transfers(input int n);
                int goal;
                goal = xfer_cnt + n;
                while (xfer_cnt < goal)
                        @(posedge clk);
        endtask

        task automatic finish_test(input int num, input string name, input int err_before);
                if (err_cnt == err_before) begin
                        tests_passed++;
                        $display("Test %0d %s: ok, %0d transfers in total", num, name, xfer_cnt);
                end else begin
                        tests_failed++;
                        $display("Test %0d %s: FAILED with %0d mismatches", num, name,
                                 err_cnt - err_before);
                end
        endtask

        // ------------------------------
        // Test sequence
        // ------------------------------
        initial begin
                int err_before;
                pc_set      = 1'b0;
                pc_mux      = PC_BOOT;
                boot_addr   = BOOT_ADDR;
                jump_target = '0;
                mepc        = '0;
                trap_base   = '0;
                exc_cause   = '0;
                arready     = 1'b0;
                rdata       = '0;
                rresp       = RESP_OKAY;
                rvalid      = 1'b0;
                id_ready    = 1'b0;
                wait (arst_n === 1'b1);
                @(posedge clk);
                mem_en = 1'b1;

                err_before = err_cnt;
                run_transfers(N_BOOT);
                finish_test(1, "boot stream", err_before);

                err_before = err_cnt;
                redir_thr  = 2;
                ready_thr  = 12;
                run_transfers(N_REDIR);
                finish_test(2, "random redirects", err_before);

                err_before = err_cnt;
                redir_thr  = 0;
                ready_thr  = 5;
                run_transfers(N_STALL);
                finish_test(3, "decode back-pressure", err_before);

                err_before = err_cnt;
                ready_thr  = 16;
                kick_addr  = ERR_BASE;
                kick       = 1'b1;
                run_transfers(N_ERR);
                finish_test(4, "error address range", err_before);

                // Stall until the queue fills, then redirect as decode frees up
                err_before = err_cnt;
                ready_thr  = 10;
                for (int r = 0; r < N_ROUNDS; r++) begin
                        stall = 1'b1;
                        repeat (4 + rand_bits(3)) @(posedge clk);
                        kick_addr = rand_bits(30) << 2;
                        kick      = 1'b1;
                        stall     = 1'b0;
                        run_transfers(N_ROUND);
                end
                finish_test(5, "redirect with full queue", err_before);

                repeat (2) @(posedge clk);
                $display("Summary: %0d tests passed, %0d tests failed, %0d mismatches",
                         tests_passed, tests_failed, err_cnt);
                if (tests_failed == 0 && err_cnt == 0) begin
                        $display("Simulation passed");
                end else begin
                        $display("Simulation failed");
                end
                $finish;
        end

endmodule

/* if_stage.f */
logic/fetch_pkg.sv
logic/axi_lite_pkg.sv
logic/fetch_req_unit.sv
logic/prefetch_queue.sv
logic/decode_handoff.sv
logic/if_stage.sv
testbench/tb_clock_gen.sv
testbench/if_checker.sv
testbench/tb_if_stage.sv

/* Makefile */
# Verilator build and run of the fetch stage testbench

TOP := tb_if_stage

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Simulation passed"

obj_dir/V$(TOP): if_stage.f logic/*.sv testbench/*.sv
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f if_stage.f

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f if_stage.f

clean:
	rm -rf obj_dir
